// ==== hw/agen_settings.svh ====
// ========================================
// shared codes for address generation
// operand kinds, sizes, segment indices
// ========================================
`ifndef AGEN_SETTINGS_SVH
`define AGEN_SETTINGS_SVH

// operand source kinds
`define AGEN_KIND_NONE  3'd0
`define AGEN_KIND_REG   3'd1
`define AGEN_KIND_SEG   3'd2
`define AGEN_KIND_MMX   3'd3
`define AGEN_KIND_MODRM 3'd4
`define AGEN_KIND_IMM   3'd5
`define AGEN_KIND_MEM   3'd6
`define AGEN_KIND_SYS   3'd7

// operand size codes
`define AGEN_SIZE_8  3'd1
`define AGEN_SIZE_16 3'd2
`define AGEN_SIZE_32 3'd3

// segment register numbering, 6 and 7 read as zero
`define AGEN_SEG_ES 3'd0
`define AGEN_SEG_CS 3'd1
`define AGEN_SEG_SS 3'd2
`define AGEN_SEG_DS 3'd3
`define AGEN_SEG_FS 3'd4
`define AGEN_SEG_GS 3'd5

// mod field of the register form
`define AGEN_MOD_REG 2'd3

// real mode segment base shift
`define AGEN_SEG_SHIFT 4

`endif

// ==== hw/agen_pkg.sv ====
// ========================================
// vector types of the address
// generation stage
// ========================================
package agen_pkg;

    // architectural register state
    typedef logic [31:0] gpr_t;
    typedef logic [15:0] seg_t;

    // operand values leaving the stage
    typedef logic [63:0] operand_t;

    // immediate field as decoded, up to 48 bits
    typedef logic [47:0] imm_t;

    // string addresses, stack address and pc
    typedef logic [31:0] lin_addr_t;

    // operand source selection
    typedef logic [2:0] op_kind_t;

    // 8, 16 or 32 bit operand
    typedef logic [2:0] size_t;

    // general register or segment number
    typedef logic [2:0] reg_idx_t;

    // mod r/m byte, mod in [7:6] and rm in [2:0]
    typedef logic [7:0] modrm_t;

    // bit 1 marks a pop
    typedef logic [1:0] stack_op_t;

    // pass-through decode fields
    typedef logic [3:0]  alu_op_t;
    typedef logic [15:0] opcode_t;

endpackage

// ==== hw/reg_state_if.sv ====
// ========================================
// register snapshot bundle
// ========================================
`timescale 1ns/1ps

interface reg_state_if;

    // general registers in x86 encoding order
    agen_pkg::gpr_t eax;
    agen_pkg::gpr_t ecx;
    agen_pkg::gpr_t edx;
    agen_pkg::gpr_t ebx;
    agen_pkg::gpr_t esp;
    agen_pkg::gpr_t ebp;
    agen_pkg::gpr_t esi;
    agen_pkg::gpr_t edi;

    // segment selectors
    agen_pkg::seg_t es;
    agen_pkg::seg_t cs;
    agen_pkg::seg_t ss;
    agen_pkg::seg_t ds;
    agen_pkg::seg_t fs;
    agen_pkg::seg_t gs;

    modport source (
        output eax, ecx, edx, ebx, esp, ebp, esi, edi,
        output es, cs, ss, ds, fs, gs
    );

    modport sink (
        input eax, ecx, edx, ebx, esp, ebp, esi, edi,
        input es, cs, ss, ds, fs, gs
    );

endinterface

// ==== hw/reg_size_selector.sv ====
// ========================================
// general register slicing by operand size
// ========================================
`timescale 1ns/1ps
`include "agen_settings.svh"

module reg_size_selector (
    input  agen_pkg::size_t    size,
    reg_state_if.sink          regs,
    output agen_pkg::operand_t sized [8]
);

    agen_pkg::gpr_t gpr [8];

    // index order follows the register encoding
    assign gpr[0] = regs.eax;
    assign gpr[1] = regs.ecx;
    assign gpr[2] = regs.edx;
    assign gpr[3] = regs.ebx;
    assign gpr[4] = regs.esp;
    assign gpr[5] = regs.ebp;
    assign gpr[6] = regs.esi;
    assign gpr[7] = regs.edi;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            agen_pkg::gpr_t byte_src;

            // byte codes only reach eax..ebx
            byte_src = gpr[i % 4];
            case (size)
                `AGEN_SIZE_8: begin
                    // codes 4 to 7 are ah, ch, dh, bh
                    if (i < 4) begin
                        sized[i] = {56'd0, byte_src[7:0]};
                    end else begin
                        sized[i] = {56'd0, byte_src[15:8]};
                    end
                end
                `AGEN_SIZE_16: begin
                    sized[i] = {48'd0, gpr[i][15:0]};
                end
                `AGEN_SIZE_32: begin
                    sized[i] = {32'd0, gpr[i]};
                end
                default: begin
                    // mmx and unused sizes
                    sized[i] = '0;
                end
            endcase
        end
    end

endmodule

// ==== hw/operand_generator.sv ====
// ========================================
// single operand mux with address and
// register flags
// ========================================
`timescale 1ns/1ps
`include "agen_settings.svh"

module operand_generator #(
    parameter bit IS_DEST = 1'b0
) (
    input  agen_pkg::op_kind_t kind,
    input  agen_pkg::reg_idx_t reg_sel,
    input  agen_pkg::modrm_t   modrm,
    input  agen_pkg::imm_t     imm,
    input  agen_pkg::reg_idx_t seg_override,
    input  logic               seg_override_valid,
    input  agen_pkg::operand_t sized [8],
    reg_state_if.sink          regs,
    output agen_pkg::operand_t value,
    output logic               is_address,
    output logic               is_reg
);

    agen_pkg::seg_t      seg_file [8];
    agen_pkg::seg_t      mem_seg;
    agen_pkg::gpr_t      mem_index;
    agen_pkg::lin_addr_t mem_addr;
    logic [1:0]          modrm_mod;
    agen_pkg::reg_idx_t  modrm_rm;
    logic                modrm_is_reg;

    assign modrm_mod    = modrm[7:6];
    assign modrm_rm     = modrm[2:0];
    assign modrm_is_reg = (modrm_mod == `AGEN_MOD_REG);

    // segment numbers 6 and 7 have no register
    assign seg_file[`AGEN_SEG_ES] = regs.es;
    assign seg_file[`AGEN_SEG_CS] = regs.cs;
    assign seg_file[`AGEN_SEG_SS] = regs.ss;
    assign seg_file[`AGEN_SEG_DS] = regs.ds;
    assign seg_file[`AGEN_SEG_FS] = regs.fs;
    assign seg_file[`AGEN_SEG_GS] = regs.gs;
    assign seg_file[6]            = '0;
    assign seg_file[7]            = '0;

    // string operand segment and index
    always_comb begin
        if (IS_DEST) begin
            // destination is ES:EDI, never overridden
            mem_seg   = regs.es;
            mem_index = regs.edi;
        end else begin
            mem_index = regs.esi;
            if (seg_override_valid) begin
                mem_seg = seg_file[seg_override];
            end else begin
                mem_seg = regs.ds;
            end
        end
    end

    // segment * 16 + index, wraps at 32 bits
    assign mem_addr = (agen_pkg::lin_addr_t'(mem_seg) << `AGEN_SEG_SHIFT) + mem_index;

    always_comb begin
        case (kind)
            `AGEN_KIND_REG: begin
                value = sized[reg_sel];
            end
            `AGEN_KIND_SEG: begin
                value = {48'd0, seg_file[reg_sel]};
            end
            `AGEN_KIND_MODRM: begin
                // memory forms carry no effective address here
                if (modrm_is_reg) begin
                    value = sized[modrm_rm];
                end else begin
                    value = '0;
                end
            end
            `AGEN_KIND_IMM: begin
                value = {16'd0, imm};
            end
            `AGEN_KIND_MEM: begin
                value = {32'd0, mem_addr};
            end
            default: begin
                // none, mmx, system controller
                value = '0;
            end
        endcase
    end

    assign is_address = (kind == `AGEN_KIND_MEM);

    // plain register, or mod r/m in register form
    assign is_reg = (kind == `AGEN_KIND_REG) ||
                    ((kind == `AGEN_KIND_MODRM) && modrm_is_reg);

endmodule

// ==== hw/agen_pipestage.sv ====
// ========================================
// one-entry valid/ready register with flush
// ========================================
`timescale 1ns/1ps

module agen_pipestage #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    logic             valid_q;
    logic [WIDTH-1:0] data_q;

    // empty, or the held item leaves this cycle
    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_data  = data_q;

    // flush wins over a new item
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload loads on acceptance only, so it holds under stall
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

// ==== hw/address_generation_top.sv ====
// ========================================
// address generation stage top level
// operand muxes, op0 flags, pop override
// and the output pipeline register
// ========================================
`timescale 1ns/1ps
`include "agen_settings.svh"

module address_generation_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,

    // decoded instruction and register snapshot
    input  logic                 r_valid,
    output logic                 r_ready,
    input  agen_pkg::size_t      r_size,
    input  agen_pkg::op_kind_t   r_op0,
    input  agen_pkg::op_kind_t   r_op1,
    input  agen_pkg::reg_idx_t   r_op0_reg,
    input  agen_pkg::reg_idx_t   r_op1_reg,
    input  agen_pkg::modrm_t     r_modrm,
    input  agen_pkg::imm_t       r_imm,
    input  agen_pkg::alu_op_t    r_alu_op,
    input  agen_pkg::stack_op_t  r_stack_op,
    input  agen_pkg::lin_addr_t  r_stack_address,
    input  agen_pkg::reg_idx_t   r_seg_override,
    input  logic                 r_seg_override_valid,
    input  agen_pkg::gpr_t       r_eax, r_ecx, r_edx, r_ebx,
    input  agen_pkg::gpr_t       r_esp, r_ebp, r_esi, r_edi,
    input  agen_pkg::seg_t       r_cs, r_ds, r_es, r_fs, r_gs, r_ss,
    input  agen_pkg::lin_addr_t  r_pc,
    input  agen_pkg::opcode_t    r_opcode,

    // toward memory access
    output logic                 a_valid,
    input  logic                 a_ready,
    output agen_pkg::size_t      a_size,
    output agen_pkg::operand_t   a_op0,
    output agen_pkg::operand_t   a_op1,
    output agen_pkg::reg_idx_t   a_op0_reg,
    output agen_pkg::reg_idx_t   a_op1_reg,
    output logic                 a_op0_is_address,
    output logic                 a_op0_is_reg,
    output logic                 a_op0_is_segment,
    output logic                 a_op1_is_reg,
    output logic                 a_op1_is_address,
    output agen_pkg::imm_t       a_imm,
    output agen_pkg::alu_op_t    a_alu_op,
    output agen_pkg::stack_op_t  a_stack_op,
    output agen_pkg::lin_addr_t  a_stack_address,
    output agen_pkg::lin_addr_t  a_pc,
    output logic                 a_to_sys_controller,
    output agen_pkg::opcode_t    a_opcode
);

    localparam int PIPE_WIDTH = $bits(agen_pkg::size_t) +
                                2 * $bits(agen_pkg::operand_t) +
                                2 * $bits(agen_pkg::reg_idx_t) + 5 +
                                $bits(agen_pkg::imm_t) + $bits(agen_pkg::alu_op_t) +
                                $bits(agen_pkg::stack_op_t) +
                                2 * $bits(agen_pkg::lin_addr_t) + 1 +
                                $bits(agen_pkg::opcode_t);

    agen_pkg::operand_t    sized_regs [8];
    agen_pkg::operand_t    p_op0;
    agen_pkg::operand_t    gen_op1;
    agen_pkg::operand_t    p_op1;
    logic                  p_op0_is_address;
    logic                  p_op0_is_reg;
    logic                  p_op0_is_segment;
    logic                  p_op1_is_reg;
    logic                  gen_op1_is_address;
    logic                  p_op1_is_address;
    logic                  p_to_sys_controller;
    logic                  pop;
    logic [PIPE_WIDTH-1:0] pipe_in_data;
    logic [PIPE_WIDTH-1:0] pipe_out_data;

    reg_state_if regs_if ();

    assign regs_if.eax = r_eax;
    assign regs_if.ecx = r_ecx;
    assign regs_if.edx = r_edx;
    assign regs_if.ebx = r_ebx;
    assign regs_if.esp = r_esp;
    assign regs_if.ebp = r_ebp;
    assign regs_if.esi = r_esi;
    assign regs_if.edi = r_edi;
    assign regs_if.es  = r_es;
    assign regs_if.cs  = r_cs;
    assign regs_if.ss  = r_ss;
    assign regs_if.ds  = r_ds;
    assign regs_if.fs  = r_fs;
    assign regs_if.gs  = r_gs;

    // one slicer feeds both operand muxes
    reg_size_selector reg_size_selector_inst (
        .size  (r_size),
        .regs  (regs_if.sink),
        .sized (sized_regs)
    );

    // op0 is the string destination
    operand_generator #(.IS_DEST(1'b1)) op0_generator_inst (
        .kind               (r_op0),
        .reg_sel            (r_op0_reg),
        .modrm              (r_modrm),
        .imm                (r_imm),
        .seg_override       (r_seg_override),
        .seg_override_valid (r_seg_override_valid),
        .sized              (sized_regs),
        .regs               (regs_if.sink),
        .value              (p_op0),
        .is_address         (p_op0_is_address),
        .is_reg             (p_op0_is_reg)
    );

    operand_generator #(.IS_DEST(1'b0)) op1_generator_inst (
        .kind               (r_op1),
        .reg_sel            (r_op1_reg),
        .modrm              (r_modrm),
        .imm                (r_imm),
        .seg_override       (r_seg_override),
        .seg_override_valid (r_seg_override_valid),
        .sized              (sized_regs),
        .regs               (regs_if.sink),
        .value              (gen_op1),
        .is_address         (gen_op1_is_address),
        .is_reg             (p_op1_is_reg)
    );

    // op0 destination kind flags
    assign p_op0_is_segment    = (r_op0 == `AGEN_KIND_SEG);
    assign p_to_sys_controller = (r_op0 == `AGEN_KIND_SYS);

    // a pop reads op1 from the stack slot
    assign pop              = r_stack_op[1];
    assign p_op1            = pop ? {32'd0, r_stack_address} : gen_op1;
    assign p_op1_is_address = gen_op1_is_address || pop;

    assign pipe_in_data = {
        r_size, p_op0, p_op1, r_op0_reg, r_op1_reg,
        p_op0_is_address, p_op0_is_reg, p_op0_is_segment,
        p_op1_is_reg, p_op1_is_address,
        r_imm, r_alu_op, r_stack_op, r_stack_address, r_pc,
        p_to_sys_controller, r_opcode
    };

    agen_pipestage #(.WIDTH(PIPE_WIDTH)) agen_pipestage_inst (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (pipe_in_data),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_data  (pipe_out_data)
    );

    assign {
        a_size, a_op0, a_op1, a_op0_reg, a_op1_reg,
        a_op0_is_address, a_op0_is_reg, a_op0_is_segment,
        a_op1_is_reg, a_op1_is_address,
        a_imm, a_alu_op, a_stack_op, a_stack_address, a_pc,
        a_to_sys_controller, a_opcode
    } = pipe_out_data;

endmodule

// ==== sim/agen_model.svh ====
// ========================================
// expected outputs of the address stage
// and typed compare tasks
// ========================================
`ifndef AGEN_MODEL_SVH
`define AGEN_MODEL_SVH

// one expected output beat
typedef struct packed {
    agen_pkg::size_t     size;
    agen_pkg::operand_t  op0;
    agen_pkg::operand_t  op1;
    agen_pkg::reg_idx_t  op0_reg;
    agen_pkg::reg_idx_t  op1_reg;
    logic                op0_is_address;
    logic                op0_is_reg;
    logic                op0_is_segment;
    logic                op1_is_reg;
    logic                op1_is_address;
    agen_pkg::imm_t      imm;
    agen_pkg::alu_op_t   alu_op;
    agen_pkg::stack_op_t stack_op;
    agen_pkg::lin_addr_t stack_address;
    agen_pkg::lin_addr_t pc;
    logic                to_sys_controller;
    agen_pkg::opcode_t   opcode;
} expect_t;

// general register value at the current operand size
function automatic agen_pkg::operand_t model_sized(input agen_pkg::reg_idx_t idx);
    agen_pkg::gpr_t full;
    full = gpr[idx];
    if (r_size == `AGEN_SIZE_8) begin
        // codes 4 to 7 are the high bytes of eax..ebx
        full = gpr[{1'b0, idx[1:0]}];
        if (idx[2]) begin
            return {56'd0, full[15:8]};
        end
        return {56'd0, full[7:0]};
    end
    if (r_size == `AGEN_SIZE_16) begin
        return {48'd0, full[15:0]};
    end
    if (r_size == `AGEN_SIZE_32) begin
        return {32'd0, full};
    end
    return '0;
endfunction

function automatic agen_pkg::seg_t model_segment(input agen_pkg::reg_idx_t idx);
    if (idx < 3'd6) begin
        return seg[idx];
    end
    return '0;
endfunction

// real mode string address, base times 16 plus index
function automatic agen_pkg::lin_addr_t model_string_addr(input bit is_dest);
    agen_pkg::seg_t base;
    agen_pkg::gpr_t index;
    if (is_dest) begin
        base  = seg[`AGEN_SEG_ES];
        index = gpr[7];
    end else begin
        index = gpr[6];
        base  = r_seg_override_valid ? model_segment(r_seg_override) : seg[`AGEN_SEG_DS];
    end
    return (agen_pkg::lin_addr_t'(base) * 32'd16) + index;
endfunction

function automatic agen_pkg::operand_t model_operand(
    input  agen_pkg::op_kind_t kind,
    input  agen_pkg::reg_idx_t sel,
    input  bit                 is_dest,
    output logic               is_address,
    output logic               is_reg
);
    logic mod_reg;
    mod_reg    = (r_modrm[7:6] == 2'b11);
    is_address = (kind == `AGEN_KIND_MEM);
    is_reg     = (kind == `AGEN_KIND_REG) || ((kind == `AGEN_KIND_MODRM) && mod_reg);
    case (kind)
        `AGEN_KIND_REG:   return model_sized(sel);
        `AGEN_KIND_SEG:   return {48'd0, model_segment(sel)};
        `AGEN_KIND_MODRM: return mod_reg ? model_sized(r_modrm[2:0]) : '0;
        `AGEN_KIND_IMM:   return {16'd0, r_imm};
        `AGEN_KIND_MEM:   return {32'd0, model_string_addr(is_dest)};
        default:          return '0;
    endcase
endfunction

// expected beat for the inputs presented this cycle
function automatic expect_t expected_item();
    expect_t e;
    e.op0 = model_operand(r_op0, r_op0_reg, 1'b1, e.op0_is_address, e.op0_is_reg);
    e.op1 = model_operand(r_op1, r_op1_reg, 1'b0, e.op1_is_address, e.op1_is_reg);
    // pop takes op1 from the stack slot
    if (r_stack_op[1]) begin
        e.op1            = {32'd0, r_stack_address};
        e.op1_is_address = 1'b1;
    end
    e.size              = r_size;
    e.op0_reg           = r_op0_reg;
    e.op1_reg           = r_op1_reg;
    e.op0_is_segment    = (r_op0 == `AGEN_KIND_SEG);
    e.to_sys_controller = (r_op0 == `AGEN_KIND_SYS);
    e.imm               = r_imm;
    e.alu_op            = r_alu_op;
    e.stack_op          = r_stack_op;
    e.stack_address     = r_stack_address;
    e.pc                = r_pc;
    e.opcode            = r_opcode;
    return e;
endfunction

task automatic check_operand(input string name, input agen_pkg::operand_t got,
                             input agen_pkg::operand_t want);
    if (got !== want) begin
        $display("** Error %s: got %h, expected %h", name, got, want);
        fail_run();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
        $display("** Error %s: got %h, expected %h", name, got, want);
        fail_run();
    end
endtask

task automatic check_field(input string name, input agen_pkg::lin_addr_t got,
                           input agen_pkg::lin_addr_t want);
    if (got !== want) begin
        $display("** Error %s: got %h, expected %h", name, got, want);
        fail_run();
    end
endtask

`endif

// ==== sim/tb_address_generation_top.sv ====
// ========================================
// testbench for the address generation
// stage, random stimulus and scoreboard
// ========================================
`timescale 1ns/1ps
`include "agen_settings.svh"

module tb_address_generation_top;

    localparam int NUM_TXN        = 3000;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 8 + 16;

    logic                clk;
    logic                reset;
    logic                flush;
    logic                r_valid;
    logic                r_ready;
    agen_pkg::size_t     r_size;
    agen_pkg::op_kind_t  r_op0;
    agen_pkg::op_kind_t  r_op1;
    agen_pkg::reg_idx_t  r_op0_reg;
    agen_pkg::reg_idx_t  r_op1_reg;
    agen_pkg::modrm_t    r_modrm;
    agen_pkg::imm_t      r_imm;
    agen_pkg::alu_op_t   r_alu_op;
    agen_pkg::stack_op_t r_stack_op;
    agen_pkg::lin_addr_t r_stack_address;
    agen_pkg::reg_idx_t  r_seg_override;
    logic                r_seg_override_valid;
    agen_pkg::lin_addr_t r_pc;
    agen_pkg::opcode_t   r_opcode;
    logic                a_ready;
    // register snapshot in encoding order
    agen_pkg::gpr_t      gpr [8];
    agen_pkg::seg_t      seg [6];

    logic                a_valid;
    agen_pkg::size_t     a_size;
    agen_pkg::operand_t  a_op0;
    agen_pkg::operand_t  a_op1;
    agen_pkg::reg_idx_t  a_op0_reg;
    agen_pkg::reg_idx_t  a_op1_reg;
    logic                a_op0_is_address;
    logic                a_op0_is_reg;
    logic                a_op0_is_segment;
    logic                a_op1_is_reg;
    logic                a_op1_is_address;
    agen_pkg::imm_t      a_imm;
    agen_pkg::alu_op_t   a_alu_op;
    agen_pkg::stack_op_t a_stack_op;
    agen_pkg::lin_addr_t a_stack_address;
    agen_pkg::lin_addr_t a_pc;
    logic                a_to_sys_controller;
    agen_pkg::opcode_t   a_opcode;

    task automatic fail_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

`include "agen_model.svh"

    logic [31:0]         rng_state;
    int                  accepted_count = 0;
    int                  cycle_count = 0;

    expect_t             expect_q [$];

    address_generation_top address_generation_top_inst (
        .clk(clk), .reset(reset), .flush(flush),
        .r_valid(r_valid), .r_ready(r_ready), .r_size(r_size),
        .r_op0(r_op0), .r_op1(r_op1), .r_op0_reg(r_op0_reg), .r_op1_reg(r_op1_reg),
        .r_modrm(r_modrm), .r_imm(r_imm), .r_alu_op(r_alu_op), .r_stack_op(r_stack_op),
        .r_stack_address(r_stack_address), .r_seg_override(r_seg_override),
        .r_seg_override_valid(r_seg_override_valid),
        .r_eax(gpr[0]), .r_ecx(gpr[1]), .r_edx(gpr[2]), .r_ebx(gpr[3]),
        .r_esp(gpr[4]), .r_ebp(gpr[5]), .r_esi(gpr[6]), .r_edi(gpr[7]),
        .r_cs(seg[`AGEN_SEG_CS]), .r_ds(seg[`AGEN_SEG_DS]), .r_es(seg[`AGEN_SEG_ES]),
        .r_fs(seg[`AGEN_SEG_FS]), .r_gs(seg[`AGEN_SEG_GS]), .r_ss(seg[`AGEN_SEG_SS]),
        .r_pc(r_pc), .r_opcode(r_opcode), .a_ready(a_ready),
        .a_valid(a_valid), .a_size(a_size), .a_op0(a_op0), .a_op1(a_op1),
        .a_op0_reg(a_op0_reg), .a_op1_reg(a_op1_reg),
        .a_op0_is_address(a_op0_is_address), .a_op0_is_reg(a_op0_is_reg),
        .a_op0_is_segment(a_op0_is_segment), .a_op1_is_reg(a_op1_is_reg),
        .a_op1_is_address(a_op1_is_address), .a_imm(a_imm), .a_alu_op(a_alu_op),
        .a_stack_op(a_stack_op), .a_stack_address(a_stack_address), .a_pc(a_pc),
        .a_to_sys_controller(a_to_sys_controller), .a_opcode(a_opcode)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic drive_stimulus();
        logic [31:0] rnd;
        rnd = next_random();
        r_valid              <= (rnd[1:0] != 2'b00);
        a_ready              <= (rnd[3:2] != 2'b00);
        flush                <= (rnd[9:4] == 6'd0);
        // mostly legal sizes, sometimes any code
        r_size               <= rnd[10] ? {1'b0, rnd[12:11]} : rnd[15:13];
        r_op0                <= rnd[18:16];
        r_op1                <= rnd[21:19];
        r_op0_reg            <= rnd[24:22];
        r_op1_reg            <= rnd[27:25];
        r_stack_op           <= {rnd[28] & rnd[29], rnd[30]};
        r_seg_override_valid <= rnd[31];
        rnd = next_random();
        r_modrm              <= rnd[7:0];
        r_seg_override       <= rnd[10:8];
        r_alu_op             <= rnd[14:11];
        r_opcode             <= rnd[31:16];
        rnd = next_random();
        r_imm[47:32]         <= rnd[15:0];
        r_imm[31:0]          <= next_random();
        r_stack_address      <= next_random();
        r_pc                 <= next_random();
        for (int i = 0; i < 8; i++) begin
            gpr[i] <= next_random();
        end
        for (int i = 0; i < 6; i++) begin
            rnd = next_random();
            seg[i] <= rnd[15:0];
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        check_operand("a_op0", a_op0, e.op0);
        check_operand("a_op1", a_op1, e.op1);
        check_operand("a_imm", {16'd0, a_imm}, {16'd0, e.imm});
        check_flag("a_op0_is_address", a_op0_is_address, e.op0_is_address);
        check_flag("a_op0_is_reg", a_op0_is_reg, e.op0_is_reg);
        check_flag("a_op0_is_segment", a_op0_is_segment, e.op0_is_segment);
        check_flag("a_op1_is_reg", a_op1_is_reg, e.op1_is_reg);
        check_flag("a_op1_is_address", a_op1_is_address, e.op1_is_address);
        check_flag("a_to_sys_controller", a_to_sys_controller, e.to_sys_controller);
        check_field("a_size", agen_pkg::lin_addr_t'(a_size), agen_pkg::lin_addr_t'(e.size));
        check_field("a_op0_reg", agen_pkg::lin_addr_t'(a_op0_reg),
                    agen_pkg::lin_addr_t'(e.op0_reg));
        check_field("a_op1_reg", agen_pkg::lin_addr_t'(a_op1_reg),
                    agen_pkg::lin_addr_t'(e.op1_reg));
        check_field("a_alu_op", agen_pkg::lin_addr_t'(a_alu_op),
                    agen_pkg::lin_addr_t'(e.alu_op));
        check_field("a_stack_op", agen_pkg::lin_addr_t'(a_stack_op),
                    agen_pkg::lin_addr_t'(e.stack_op));
        check_field("a_stack_address", a_stack_address, e.stack_address);
        check_field("a_pc", a_pc, e.pc);
        check_field("a_opcode", agen_pkg::lin_addr_t'(a_opcode),
                    agen_pkg::lin_addr_t'(e.opcode));
    endtask

    // scoreboard on the falling edge, where inputs and outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            expect_q.delete();
        end else begin
            // one entry in flight, so a_valid mirrors the queue
            check_flag("a_valid", a_valid, (expect_q.size() != 0));
            check_flag("r_ready", r_ready, ((expect_q.size() == 0) || a_ready));
            if (a_valid) begin
                compare_outputs(expect_q[0]);
                if (a_ready) begin
                    void'(expect_q.pop_front());
                end
            end
            if (flush) begin
                expect_q.delete();
            end else if (r_valid && r_ready) begin
                expect_q.push_back(expected_item());
                accepted_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    initial begin
        clk                  = 1'b0;
        reset                = 1'b1;
        flush                = 1'b0;
        r_valid              = 1'b0;
        a_ready              = 1'b0;
        r_size               = '0;
        r_op0                = '0;
        r_op1                = '0;
        r_op0_reg            = '0;
        r_op1_reg            = '0;
        r_modrm              = '0;
        r_imm                = '0;
        r_alu_op             = '0;
        r_stack_op           = '0;
        r_stack_address      = '0;
        r_seg_override       = '0;
        r_seg_override_valid = 1'b0;
        r_pc                 = '0;
        r_opcode             = '0;
        for (int i = 0; i < 8; i++) begin
            gpr[i] = '0;
        end
        for (int i = 0; i < 6; i++) begin
            seg[i] = '0;
        end
        rng_state = 32'h6ace_7cdb;

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        while (accepted_count < NUM_TXN) begin
            drive_stimulus();
            @(posedge clk);
        end

        // drain the register
        r_valid <= 1'b0;
        flush   <= 1'b0;
        a_ready <= 1'b1;
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        // the scoreboard sees the emptied register once more
        repeat (2) @(posedge clk);

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hw
+incdir+sim
hw/agen_pkg.sv
hw/reg_state_if.sv
hw/reg_size_selector.sv
hw/operand_generator.sv
hw/agen_pipestage.sv
hw/address_generation_top.sv
sim/tb_address_generation_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_address_generation_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

SOURCES := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HEADERS := hw/agen_settings.svh sim/agen_model.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FLIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
